//--- core_pkg.sv
`default_nettype none

package core_pkg;

	////////////////////////////////////////
	// widths and depths
	////////////////////////////////////////

	typedef logic [31:0] data_t;

	// reorder ring entries
	localparam int ROB_DEPTH = 8;

	typedef logic [$clog2(ROB_DEPTH)-1:0] tag_t;

	// one extra bit so a full ring can be told from an empty one
	typedef logic [$clog2(ROB_DEPTH):0] count_t;

	// multiplier latency, at least 2
	localparam int MUL_LAT = 4;

	////////////////////////////////////////
	// operations and units
	////////////////////////////////////////

	typedef enum logic [1:0] {
		OP_ADD,
		OP_SUB,
		OP_MOV,
		OP_MUL
	} op_t;

	// owner of a result bus slot
	typedef enum logic {
		UNIT_ALU,
		UNIT_MUL
	} unit_t;

	typedef struct packed {
		logic valid;
		tag_t tag;
		unit_t unit;
	} rsv_t;

endpackage

`default_nettype wire

//--- issue_stage.sv
`default_nettype none

module issue_stage #(
	parameter int ROB_DEPTH = core_pkg::ROB_DEPTH
) (
	input logic issue_valid,
	input core_pkg::op_t issue_op,
	input logic alu_ready,
	input logic mul_ready,
	input logic full,
	output logic issue_ready,
	output logic issue_fire,
	output logic alu_fire,
	output logic mul_fire
);
	import core_pkg::*;

	logic is_mul;
	logic unit_ready;

	// ring index has to cover every entry
	if (ROB_DEPTH < 2 || ROB_DEPTH > (1 << $bits(tag_t))) begin : g_depth_check
		$error("ROB_DEPTH %0d does not fit the tag width", ROB_DEPTH);
	end

	// only the multiply goes to the long unit
	assign is_mul = (issue_op == OP_MUL);

	assign unit_ready = is_mul ? mul_ready : alu_ready;

	// stall on a full ring or a busy bus slot
	assign issue_ready = unit_ready && !full;

	assign issue_fire = issue_valid && issue_ready;

	assign alu_fire = issue_fire && !is_mul;
	assign mul_fire = issue_fire && is_mul;

endmodule

`default_nettype wire

//--- alu_unit.sv
`default_nettype none

module alu_unit (
	input logic clk,
	input logic alu_fire,
	input core_pkg::op_t issue_op,
	input core_pkg::data_t issue_a,
	input core_pkg::data_t issue_b,
	output core_pkg::data_t alu_result
);
	import core_pkg::*;

	data_t result_next;

	always_comb begin
		case (issue_op)
			OP_ADD: begin
				result_next = issue_a + issue_b;
			end
			OP_SUB: begin
				result_next = issue_a - issue_b;
			end
			default: begin
				// mov passes a through
				result_next = issue_a;
			end
		endcase
	end

	// held until the next fire, bus reads it one cycle after
	always_ff @(posedge clk) begin
		if (alu_fire) begin
			alu_result <= result_next;
		end
	end

endmodule

`default_nettype wire

//--- mul_unit.sv
`default_nettype none

module mul_unit #(
	parameter int MUL_LAT = core_pkg::MUL_LAT
) (
	input logic clk,
	input logic mul_fire,
	input core_pkg::data_t issue_a,
	input core_pkg::data_t issue_b,
	output core_pkg::data_t mul_result
);
	import core_pkg::*;

	// low word of the product only
	data_t product;
	data_t stage [MUL_LAT];

	assign product = issue_a * issue_b;

	// first stage loads on fire
	always_ff @(posedge clk) begin
		if (mul_fire) begin
			stage[0] <= product;
		end
	end

	// remaining stages move every cycle
	always_ff @(posedge clk) begin
		for (int i = 1; i < MUL_LAT; i++) begin
			stage[i] <= stage[i-1];
		end
	end

	// last stage lines up with slot 0 of its reservation
	assign mul_result = stage[MUL_LAT-1];

endmodule

`default_nettype wire

//--- cdb_sched.sv
`default_nettype none

module cdb_sched #(
	parameter int MUL_LAT = core_pkg::MUL_LAT
) (
	input logic clk,
	input logic reset,
	input logic alu_fire,
	input logic mul_fire,
	input core_pkg::tag_t alloc_tag,
	input core_pkg::data_t alu_result,
	input core_pkg::data_t mul_result,
	output logic alu_ready,
	output logic mul_ready,
	output logic cdb_valid,
	output core_pkg::tag_t cdb_tag,
	output core_pkg::data_t cdb_data
);
	import core_pkg::*;

	////////////////////////////////////////
	// reservation slots
	////////////////////////////////////////

	// slot i reaches the bus in i cycles
	rsv_t slot [MUL_LAT];
	rsv_t alu_entry;
	rsv_t mul_entry;

	if (MUL_LAT < 2) begin : g_lat_check
		$error("MUL_LAT %0d is below the minimum of 2", MUL_LAT);
	end

	assign alu_entry = '{valid: 1'b1, tag: alloc_tag, unit: UNIT_ALU};
	assign mul_entry = '{valid: 1'b1, tag: alloc_tag, unit: UNIT_MUL};

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < MUL_LAT; i++) begin
				slot[i] <= '0;
			end
		end else begin
			for (int i = 0; i < MUL_LAT - 1; i++) begin
				slot[i] <= slot[i+1];
			end
			slot[MUL_LAT-1] <= mul_fire ? mul_entry : '0;
			// alu only fires when slot 1 is empty, so nothing is dropped here
			if (alu_fire) begin
				slot[0] <= alu_entry;
			end
		end
	end

	////////////////////////////////////////
	// unit ready
	////////////////////////////////////////

	// slot 1 moves into slot 0, which is where an alu result lands
	assign alu_ready = !slot[1].valid;

	// top slot is never claimed by anyone else
	assign mul_ready = 1'b1;

	////////////////////////////////////////
	// result bus
	////////////////////////////////////////

	assign cdb_valid = slot[0].valid;
	assign cdb_tag = slot[0].tag;
	assign cdb_data = (slot[0].unit == UNIT_MUL) ? mul_result : alu_result;

endmodule

`default_nettype wire

//--- reorder_ring.sv
`default_nettype none

module reorder_ring #(
	parameter int ROB_DEPTH = core_pkg::ROB_DEPTH
) (
	input logic clk,
	input logic reset,
	input logic issue_fire,
	input logic cdb_valid,
	input core_pkg::tag_t cdb_tag,
	input core_pkg::data_t cdb_data,
	output core_pkg::tag_t alloc_tag,
	output logic full,
	output logic commit_valid,
	output core_pkg::tag_t commit_tag,
	output core_pkg::data_t commit_data
);
	import core_pkg::*;

	tag_t head;
	tag_t tail;
	count_t count;
	data_t data_mem [ROB_DEPTH];
	logic [ROB_DEPTH-1:0] done;

	// wraps at the ring depth, not at the tag width
	function automatic tag_t next_tag(input tag_t t);
		return (t == tag_t'(ROB_DEPTH - 1)) ? '0 : t + 1'b1;
	endfunction

	////////////////////////////////////////
	// allocation
	////////////////////////////////////////

	assign alloc_tag = tail;
	assign full = (count == count_t'(ROB_DEPTH));

	always_ff @(posedge clk) begin
		if (reset) begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end else begin
			if (issue_fire) begin
				tail <= next_tag(tail);
			end
			if (commit_valid) begin
				head <= next_tag(head);
			end
			count <= count + count_t'(issue_fire) - count_t'(commit_valid);
		end
	end

	////////////////////////////////////////
	// results and commit
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (cdb_valid) begin
			data_mem[cdb_tag] <= cdb_data;
		end
	end

	// bus and commit never touch the same entry in one cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			done <= '0;
		end else begin
			if (cdb_valid) begin
				done[cdb_tag] <= 1'b1;
			end
			if (commit_valid) begin
				done[head] <= 1'b0;
			end
		end
	end

	assign commit_valid = (count != '0) && done[head];
	assign commit_tag = head;
	assign commit_data = data_mem[head];

endmodule

`default_nettype wire

//--- exec_core.sv
`default_nettype none

module exec_core #(
	parameter int ROB_DEPTH = core_pkg::ROB_DEPTH,
	parameter int MUL_LAT = core_pkg::MUL_LAT
) (
	input logic clk,
	input logic reset,
	input logic issue_valid,
	input core_pkg::op_t issue_op,
	input core_pkg::data_t issue_a,
	input core_pkg::data_t issue_b,
	output logic issue_ready,
	output logic commit_valid,
	output core_pkg::tag_t commit_tag,
	output core_pkg::data_t commit_data
);
	import core_pkg::*;

	////////////////////////////////////////
	// internal nets
	////////////////////////////////////////

	logic issue_fire;
	logic alu_fire;
	logic mul_fire;
	logic alu_ready;
	logic mul_ready;
	logic full;
	tag_t alloc_tag;
	data_t alu_result;
	data_t mul_result;

	// result bus
	logic cdb_valid;
	tag_t cdb_tag;
	data_t cdb_data;

	////////////////////////////////////////
	// stages
	////////////////////////////////////////

	issue_stage #(.ROB_DEPTH(ROB_DEPTH)) issue_stage (
		.issue_valid,
		.issue_op,
		.alu_ready,
		.mul_ready,
		.full,
		.issue_ready,
		.issue_fire,
		.alu_fire,
		.mul_fire
	);

	alu_unit alu_unit (
		.clk,
		.alu_fire,
		.issue_op,
		.issue_a,
		.issue_b,
		.alu_result
	);

	mul_unit #(.MUL_LAT(MUL_LAT)) mul_unit (
		.clk,
		.mul_fire,
		.issue_a,
		.issue_b,
		.mul_result
	);

	cdb_sched #(.MUL_LAT(MUL_LAT)) cdb_sched (
		.clk,
		.reset,
		.alu_fire,
		.mul_fire,
		.alloc_tag,
		.alu_result,
		.mul_result,
		.alu_ready,
		.mul_ready,
		.cdb_valid,
		.cdb_tag,
		.cdb_data
	);

	reorder_ring #(.ROB_DEPTH(ROB_DEPTH)) reorder_ring (
		.clk,
		.reset,
		.issue_fire,
		.cdb_valid,
		.cdb_tag,
		.cdb_data,
		.alloc_tag,
		.full,
		.commit_valid,
		.commit_tag,
		.commit_data
	);

endmodule

`default_nettype wire

//--- exec_core_chk.sv
`default_nettype none

module exec_core_chk (
	input logic clk,
	input logic reset,
	input logic alu_fire,
	input logic mul_fire,
	input logic issue_fire,
	input logic full,
	input logic cdb_valid,
	input core_pkg::tag_t cdb_tag,
	input logic commit_valid,
	input core_pkg::tag_t commit_tag
);
	import core_pkg::*;

	// shadow of the ring's done flags
	logic [(1 << $bits(tag_t))-1:0] done_seen;

	always_ff @(posedge clk) begin
		if (reset) begin
			done_seen <= '0;
		end else begin
			if (cdb_valid) begin
				done_seen[cdb_tag] <= 1'b1;
			end
			if (commit_valid) begin
				done_seen[commit_tag] <= 1'b0;
			end
		end
	end

	a_one_unit: assert property (@(posedge clk) disable iff (reset) !(alu_fire && mul_fire))
		else $error("alu_fire and mul_fire high in the same cycle");

	a_full_stall: assert property (@(posedge clk) disable iff (reset) full |-> !issue_fire)
		else $error("issue_fire while the reorder ring is full");

	a_no_rewrite: assert property (@(posedge clk) disable iff (reset)
		cdb_valid |-> !done_seen[cdb_tag])
		else $error("result bus wrote an entry that is already done");

	a_reset_quiet: assert property (@(posedge clk) reset |=> !commit_valid)
		else $error("commit_valid high in the cycle after reset");

endmodule

bind exec_core exec_core_chk chk0 (
	.clk(clk),
	.reset(reset),
	.alu_fire(alu_fire),
	.mul_fire(mul_fire),
	.issue_fire(issue_fire),
	.full(full),
	.cdb_valid(cdb_valid),
	.cdb_tag(cdb_tag),
	.commit_valid(commit_valid),
	.commit_tag(commit_tag)
);

`default_nettype wire

//--- tb_clock.sv
`default_nettype none

module tb_clock #(
	parameter int PERIOD = 100,
	parameter int RESET_CYCLES = 5
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire

//--- tb_exec_core.sv
`default_nettype none

module tb_exec_core;
	import core_pkg::*;

	// small ring so that multiply bursts can fill it
	localparam int RING_DEPTH = 5;
	localparam int LIMIT = 100;

	typedef struct packed {
		tag_t tag;
		data_t result;
		int fire_cycle;
	} expect_t;

	logic clk;
	logic reset;
	logic issue_valid;
	op_t issue_op;
	data_t issue_a;
	data_t issue_b;
	logic issue_ready;
	logic commit_valid;
	tag_t commit_tag;
	data_t commit_data;

	expect_t model_q[$];
	// mul_hist[k] is a multiply fire k+1 cycles back
	logic mul_hist [MUL_LAT-1];
	logic [15:0] lfsr;
	logic want_issue;
	int cycle;
	int issued;
	int expect_latency;
	int full_stalls;
	int alu_stalls;

	tb_clock clock0 (.clk, .reset);

	exec_core #(.ROB_DEPTH(RING_DEPTH), .MUL_LAT(MUL_LAT)) dut0 (
		.clk,
		.reset,
		.issue_valid,
		.issue_op,
		.issue_a,
		.issue_b,
		.issue_ready,
		.commit_valid,
		.commit_tag,
		.commit_data
	);

	task automatic abort_run();
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic timeout(input string what);
		$display("timed out waiting for %s", what);
		abort_run();
	endtask

	task automatic compare_data(input data_t got, input data_t exp, input string what);
		if (got !== exp) begin
			$display("Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic compare_tag(input tag_t got, input tag_t exp, input string what);
		if (got !== exp) begin
			$display("Error at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic compare_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("Error at time %0t: %s is %b, expected %b", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic compare_count(input int got, input int exp, input string what);
		if (got != exp) begin
			$display("Error at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
			abort_run();
		end
	endtask

	// taps 16, 14, 13, 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	function automatic data_t predict(input op_t op, input data_t a, input data_t b);
		logic [63:0] prod;
		prod = {32'b0, a} * {32'b0, b};
		case (op)
			OP_ADD: return a + b;
			OP_SUB: return a - b;
			OP_MOV: return a;
			default: return prod[31:0];
		endcase
	endfunction

	task automatic observe_cycle(output logic fired);
		expect_t e;
		logic ready_exp;
		logic slot_taken;
		fired = issue_valid && issue_ready;
		slot_taken = (issue_op != OP_MUL) && mul_hist[MUL_LAT-2];
		ready_exp = (model_q.size() < RING_DEPTH) && !slot_taken;
		compare_flag(issue_ready, ready_exp, "issue_ready");
		if (issue_valid && model_q.size() == RING_DEPTH) begin
			full_stalls++;
		end
		if (issue_valid && slot_taken) begin
			alu_stalls++;
		end
		if (commit_valid) begin
			if (model_q.size() == 0) begin
				$display("commit at time %0t with no instruction outstanding", $time);
				abort_run();
			end
			e = model_q.pop_front();
			compare_tag(commit_tag, e.tag, "commit_tag");
			compare_data(commit_data, e.result, "commit_data");
			if (expect_latency != 0) begin
				compare_count(cycle - e.fire_cycle, expect_latency, "commit latency");
			end
		end
		if (fired) begin
			e = '{tag_t'(issued % RING_DEPTH), predict(issue_op, issue_a, issue_b), cycle};
			model_q.push_back(e);
			issued++;
		end
		for (int i = MUL_LAT - 2; i > 0; i--) begin
			mul_hist[i] = mul_hist[i-1];
		end
		mul_hist[0] = fired && (issue_op == OP_MUL);
		cycle++;
	endtask

	// observe on the falling edge, return on the rising edge to drive
	task automatic step(output logic fired);
		@(negedge clk);
		observe_cycle(fired);
		@(posedge clk);
	endtask

	task automatic drive_random(input logic mul_heavy);
		logic [31:0] bits;
		take_bits(2, bits);
		want_issue = (bits[1:0] != 2'b00);
		issue_valid <= want_issue;
		take_bits(2, bits);
		if (mul_heavy) begin
			issue_op <= (bits[1:0] == 2'b00) ? OP_ADD : OP_MUL;
		end else begin
			issue_op <= op_t'(bits[1:0]);
		end
		take_bits(32, bits);
		issue_a <= bits;
		take_bits(32, bits);
		issue_b <= bits;
	endtask

	task automatic run_random(input int cycles, input logic mul_heavy);
		logic fired;
		for (int i = 0; i < cycles; i++) begin
			step(fired);
			// a held instruction keeps its values
			if (!want_issue || fired) begin
				drive_random(mul_heavy);
			end
		end
	endtask

	task automatic drain();
		logic fired;
		int n;
		n = 0;
		while (want_issue) begin
			step(fired);
			if (fired) begin
				want_issue = 1'b0;
				issue_valid <= 1'b0;
			end
			n++;
			if (n > LIMIT) begin
				timeout("the held instruction to be accepted");
			end
		end
		n = 0;
		while (model_q.size() != 0) begin
			step(fired);
			n++;
			if (n > LIMIT) begin
				timeout("outstanding instructions to commit");
			end
		end
	endtask

	task automatic issue_alone(input op_t op, input int latency);
		logic [31:0] bits;
		drain();
		expect_latency = latency;
		want_issue = 1'b1;
		issue_valid <= 1'b1;
		issue_op <= op;
		take_bits(32, bits);
		issue_a <= bits;
		take_bits(32, bits);
		issue_b <= bits;
		drain();
		expect_latency = 0;
	endtask

	initial begin
		logic fired;
		int n;
		issue_valid = 1'b0;
		issue_op = OP_ADD;
		issue_a = '0;
		issue_b = '0;
		lfsr = 16'd90;
		want_issue = 1'b0;
		cycle = 0;
		issued = 0;
		expect_latency = 0;
		full_stalls = 0;
		alu_stalls = 0;
		for (int i = 0; i < MUL_LAT - 1; i++) begin
			mul_hist[i] = 1'b0;
		end
		n = 0;
		@(negedge clk);
		while (reset) begin
			@(negedge clk);
			n++;
			if (n > LIMIT) begin
				timeout("reset to be released");
			end
		end
		@(posedge clk);
		// idle after reset, no commit may appear
		repeat (10) step(fired);
		run_random(1500, 1'b0);
		run_random(600, 1'b1);
		issue_alone(OP_SUB, 2);
		issue_alone(OP_MUL, MUL_LAT + 1);
		drain();
		if (full_stalls == 0 || alu_stalls == 0) begin
			$display("random stimulus never filled the ring or never blocked an alu op");
			abort_run();
		end else begin
			$display("Everything OK");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- project.f
core_pkg.sv
issue_stage.sv
alu_unit.sv
mul_unit.sv
cdb_sched.sv
reorder_ring.sv
exec_core.sv
exec_core_chk.sv
tb_clock.sv
tb_exec_core.sv

//--- Makefile
TOP = tb_exec_core

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f project.f -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
